/* rtl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    localparam int pc_w = 32;

    // two-bit counter codes, bit 1 clear predicts taken
    localparam logic [1:0] cnt_w_taken  = 2'b00;
    localparam logic [1:0] cnt_s_taken  = 2'b01;
    localparam logic [1:0] cnt_wn_taken = 2'b10;
    localparam logic [1:0] cnt_sn_taken = 2'b11;

    // one table entry, 65 bits
    typedef struct packed {
        logic            valid;
        logic [1:0]      count;
        logic [pc_w-3:0] tag;     // pc bits 31:2
        logic [pc_w-1:0] target;
    } pht_entry_t;

    // resolved branch from execute, 68 bits
    typedef struct packed {
        logic [pc_w-1:0] pc;
        logic [1:0]      old_count; // count the branch carried
        logic            is_branch;
        logic            taken;
        logic [pc_w-1:0] target;
    } br_result_t;

    // prediction toward decode, 36 bits
    typedef struct packed {
        logic            taken;
        logic [1:0]      count;
        logic            valid;
        logic [pc_w-1:0] next_pc;
    } bpu_ds_t;

endpackage

`default_nettype wire

/* rtl/pht_if.sv */
`default_nettype none

interface pht_if #(
    parameter int PHT_ENTRIES = 256
);

    localparam int idx_w = $clog2(PHT_ENTRIES);

    logic                 req;    // doubles as the ram enable
    logic                 we;
    logic [idx_w-1:0]     addr;
    bpu_pkg::pht_entry_t  wdata;
    logic                 gnt;    // same-cycle grant
    bpu_pkg::pht_entry_t  rdata;  // one cycle after a granted read

    modport requester (output req, output we, output addr, output wdata,
                       input gnt, input rdata);

    modport arbiter (input req, input we, input addr, input wdata,
                     output gnt, output rdata);

    modport memory (input req, input we, input addr, input wdata,
                    output rdata);

endinterface

`default_nettype wire

/* rtl/pht_ram.sv */
`default_nettype none

module pht_ram #(
    parameter int PHT_ENTRIES = 256
) (
    input  logic   clk,
    input  logic   reset,
    pht_if.memory  mem
);

    bpu_pkg::pht_entry_t entries [PHT_ENTRIES];

    // write port
    always_ff @(posedge clk) begin
        if (mem.req && mem.we) begin
            entries[mem.addr] <= mem.wdata;
        end
    end

    // registered read, a write in the same cycle leaves rdata alone
    always_ff @(posedge clk) begin
        if (reset) begin
            mem.rdata <= '0;
        end else if (mem.req && !mem.we) begin
            mem.rdata <= entries[mem.addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/pht_arbiter.sv */
`default_nettype none

module pht_arbiter #(
    parameter int PHT_ENTRIES = 256
) (
    input  logic      clk,
    input  logic      reset,
    pht_if.arbiter    upd,
    pht_if.arbiter    lku,
    pht_if.requester  mem
);

    localparam int idx_w = $clog2(PHT_ENTRIES);

    logic             upd_sel;     // update owns the port this cycle
    logic [idx_w-1:0] sel_addr;
    logic             rd_upd_q;    // read in flight belongs to update
    logic             rd_lku_q;    // read in flight belongs to lookup

    assign upd_sel  = upd.req;
    assign sel_addr = upd_sel ? upd.addr : lku.addr;

    // update always wins, lookup takes what is left
    assign upd.gnt = upd.req;
    assign lku.gnt = lku.req & ~upd.req;

    assign mem.req   = upd.req | lku.req;
    assign mem.we    = upd_sel ? upd.we : lku.we;
    assign mem.addr  = sel_addr;
    assign mem.wdata = upd_sel ? upd.wdata : lku.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_upd_q <= 1'b0;
            rd_lku_q <= 1'b0;
        end else begin
            rd_upd_q <= upd.gnt & ~upd.we;
            rd_lku_q <= lku.gnt & ~lku.we;
        end
    end

    // only the owner of the read gets data back
    assign upd.rdata = rd_upd_q ? mem.rdata : '0;
    assign lku.rdata = rd_lku_q ? mem.rdata : '0;

endmodule

`default_nettype wire

/* rtl/bpu_lookup.sv */
`default_nettype none

module bpu_lookup #(
    parameter int PHT_ENTRIES = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [bpu_pkg::pc_w-1:0]    pre_pc,
    input  logic                        pc_valid,
    input  logic                        ds_allowin,
    pht_if.requester                    pht,
    output logic                        lookup_hit,
    output logic [bpu_pkg::pc_w-1:0]    lookup_target,
    output bpu_pkg::bpu_ds_t            ds_bus
);

    localparam int idx_w = $clog2(PHT_ENTRIES);

    logic [bpu_pkg::pc_w-1:0] pc_q;
    logic                     granted_q;  // read was actually issued
    logic [bpu_pkg::pc_w-1:0] pc_plus4;
    logic                     tag_match;
    logic                     pred_taken;
    bpu_pkg::pht_entry_t      entry;

    // read only, one request per valid fetch pc
    assign pht.req   = pc_valid;
    assign pht.we    = 1'b0;
    assign pht.addr  = pre_pc[2 +: idx_w];
    assign pht.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q      <= '0;
            granted_q <= 1'b0;
        end else begin
            pc_q      <= pre_pc;
            granted_q <= pc_valid & pht.gnt; // denied lookup becomes a miss
        end
    end

    assign entry      = pht.rdata;
    assign pc_plus4   = pc_q + 32'd4;
    assign tag_match  = entry.tag == pc_q[bpu_pkg::pc_w-1:2];
    assign pred_taken = ~entry.count[1];

    assign lookup_hit    = granted_q & entry.valid & tag_match;
    assign lookup_target = (lookup_hit && pred_taken) ? entry.target : pc_plus4;

    // decode-stage register, frozen while decode is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_bus <= '0;
        end else if (ds_allowin) begin
            if (lookup_hit) begin
                ds_bus.taken   <= pred_taken;
                ds_bus.count   <= entry.count;
                ds_bus.valid   <= 1'b1;
                ds_bus.next_pc <= lookup_target;
            end else begin
                ds_bus <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/bpu_update.sv */
`default_nettype none

module bpu_update #(
    parameter int PHT_ENTRIES = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  bpu_pkg::br_result_t   br_result,
    output logic                  bpu_ready,
    pht_if.requester              pht
);

    localparam int idx_w = $clog2(PHT_ENTRIES);

    logic [idx_w-1:0]     clr_idx;
    logic                 clearing;
    bpu_pkg::br_result_t  br_q;
    logic                 br_valid_q;  // registered branch, only once ready
    logic [1:0]           new_count;
    bpu_pkg::pht_entry_t  wr_entry;

    assign clearing = ~bpu_ready;

    // clear sweep, one entry per granted cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            clr_idx   <= '0;
            bpu_ready <= 1'b0;
        end else if (clearing && pht.gnt) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == idx_w'(PHT_ENTRIES - 1)) begin
                bpu_ready <= 1'b1; // last entry lands at this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        br_q <= br_result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            br_valid_q <= 1'b0;
        end else begin
            br_valid_q <= bpu_ready & br_result.is_branch; // dropped during sweep
        end
    end

    // saturating count, strong taken holds on taken
    always_comb begin
        case (br_q.old_count)
            bpu_pkg::cnt_sn_taken:
                new_count = br_q.taken ? bpu_pkg::cnt_wn_taken : bpu_pkg::cnt_sn_taken;
            bpu_pkg::cnt_wn_taken:
                new_count = br_q.taken ? bpu_pkg::cnt_w_taken : bpu_pkg::cnt_sn_taken;
            bpu_pkg::cnt_w_taken:
                new_count = br_q.taken ? bpu_pkg::cnt_s_taken : bpu_pkg::cnt_wn_taken;
            default:
                new_count = br_q.taken ? bpu_pkg::cnt_s_taken : bpu_pkg::cnt_w_taken;
        endcase
    end

    always_comb begin
        if (clearing) begin
            wr_entry = '0; // invalid entry
        end else begin
            wr_entry.valid  = 1'b1;
            wr_entry.count  = new_count;
            wr_entry.tag    = br_q.pc[bpu_pkg::pc_w-1:2];
            wr_entry.target = br_q.target;
        end
    end

    // write-only port
    assign pht.req   = clearing | br_valid_q;
    assign pht.we    = 1'b1;
    assign pht.addr  = clearing ? clr_idx : br_q.pc[2 +: idx_w];
    assign pht.wdata = wr_entry;

endmodule

`default_nettype wire

/* rtl/bpu_top.sv */
`default_nettype none

module bpu_top #(
    parameter int PHT_ENTRIES = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [bpu_pkg::pc_w-1:0]    pre_pc,
    input  logic                        pc_valid,
    input  logic                        ds_allowin,
    input  bpu_pkg::br_result_t         br_result,
    output logic                        lookup_hit,
    output logic [bpu_pkg::pc_w-1:0]    lookup_target,
    output bpu_pkg::bpu_ds_t            ds_bus,
    output logic                        bpu_ready
);

    pht_if #(.PHT_ENTRIES(PHT_ENTRIES)) upd_port ();
    pht_if #(.PHT_ENTRIES(PHT_ENTRIES)) lku_port ();
    pht_if #(.PHT_ENTRIES(PHT_ENTRIES)) mem_port ();

    bpu_update #(.PHT_ENTRIES(PHT_ENTRIES)) u_update (
        .clk       (clk),
        .reset     (reset),
        .br_result (br_result),
        .bpu_ready (bpu_ready),
        .pht       (upd_port.requester)
    );

    bpu_lookup #(.PHT_ENTRIES(PHT_ENTRIES)) u_lookup (
        .clk           (clk),
        .reset         (reset),
        .pre_pc        (pre_pc),
        .pc_valid      (pc_valid),
        .ds_allowin    (ds_allowin),
        .pht           (lku_port.requester),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .ds_bus        (ds_bus)
    );

    pht_arbiter #(.PHT_ENTRIES(PHT_ENTRIES)) u_arbiter (
        .clk   (clk),
        .reset (reset),
        .upd   (upd_port.arbiter),
        .lku   (lku_port.arbiter),
        .mem   (mem_port.requester)
    );

    pht_ram #(.PHT_ENTRIES(PHT_ENTRIES)) u_ram (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_port.memory)
    );

endmodule

`default_nettype wire

/* tb/bpu_tb_model.svh */
`ifndef BPU_TB_MODEL_SVH
`define BPU_TB_MODEL_SVH

// expected lookup outcome for one pc
typedef struct packed {
    logic        hit;
    logic [31:0] target;
    logic [1:0]  count;
} pred_t;

bpu_pkg::pht_entry_t model_pht [PHT_ENTRIES];

function automatic void clear_model();
    foreach (model_pht[i]) begin
        model_pht[i] = '0;
    end
endfunction

// saturating two-bit count, strong taken holds on taken
function automatic logic [1:0] next_count(input logic [1:0] old_count, input logic taken);
    case (old_count)
        bpu_pkg::cnt_sn_taken: return taken ? bpu_pkg::cnt_wn_taken : bpu_pkg::cnt_sn_taken;
        bpu_pkg::cnt_wn_taken: return taken ? bpu_pkg::cnt_w_taken : bpu_pkg::cnt_sn_taken;
        bpu_pkg::cnt_w_taken:  return taken ? bpu_pkg::cnt_s_taken : bpu_pkg::cnt_wn_taken;
        default:               return taken ? bpu_pkg::cnt_s_taken : bpu_pkg::cnt_w_taken;
    endcase
endfunction

// resolved branch as it lands in the table
function automatic void write_model(input bpu_pkg::br_result_t br);
    bpu_pkg::pht_entry_t e;
    e.valid  = 1'b1;
    e.count  = next_count(br.old_count, br.taken);
    e.tag    = br.pc[31:2];
    e.target = br.target;
    model_pht[br.pc[2 +: idx_w]] = e;
endfunction

function automatic pred_t expect_pred(input logic [31:0] pc);
    bpu_pkg::pht_entry_t e;
    pred_t p;
    e        = model_pht[pc[2 +: idx_w]];
    p.hit    = e.valid && (e.tag == pc[31:2]);
    p.count  = p.hit ? e.count : 2'b00;
    p.target = (p.hit && !e.count[1]) ? e.target : pc + 32'd4; // fall through unless taken
    return p;
endfunction

`endif

/* tb/bpu_tb.sv */
`default_nettype none

module bpu_tb;

    localparam int PHT_ENTRIES = 64;
    localparam int idx_w = $clog2(PHT_ENTRIES);

    `include "bpu_tb_model.svh"

    typedef struct packed {
        int          stamp;  // cycle the lookup was driven in
        logic        lk;
        logic [31:0] pc;
        pred_t       exp;
    } lookup_rec_t;

    logic                clk;
    logic                reset;
    logic [31:0]         pre_pc;
    logic                pc_valid;
    logic                ds_allowin;
    bpu_pkg::br_result_t br_result;
    logic                lookup_hit;
    logic [31:0]         lookup_target;
    bpu_pkg::bpu_ds_t    ds_bus;
    logic                bpu_ready;

    lookup_rec_t         rec_q [$];
    bpu_pkg::bpu_ds_t    exp_ds;
    int                  cyc = 0;
    int                  lookup_errors = 0;
    int                  ds_errors = 0;
    int                  ready_errors = 0;
    int                  timeout_errors = 0;
    integer              seed;
    logic                wr_pend;    // write issued in the cycle being driven
    bpu_pkg::br_result_t wr_br;
    logic [31:0]         pc_a, pc_b, pc_c, pc_d;
    logic [31:0]         tgt_a, tgt_c, tgt_d;

    bpu_top #(.PHT_ENTRIES(PHT_ENTRIES)) dut_i (
        .clk           (clk),
        .reset         (reset),
        .pre_pc        (pre_pc),
        .pc_valid      (pc_valid),
        .ds_allowin    (ds_allowin),
        .br_result     (br_result),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .ds_bus        (ds_bus),
        .bpu_ready     (bpu_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] random_pc();
        return $random(seed) & 32'hffff_fffc; // word aligned
    endfunction

    function automatic bpu_pkg::br_result_t make_branch(input logic [31:0] pc,
            input logic [1:0] old_count, input logic taken, input logic [31:0] target);
        bpu_pkg::br_result_t br;
        br.pc        = pc;
        br.old_count = old_count;
        br.is_branch = 1'b1;
        br.taken     = taken;
        br.target    = target;
        return br;
    endfunction

    function automatic logic [1:0] model_count(input logic [31:0] pc);
        return model_pht[pc[2 +: idx_w]].count;
    endfunction

    // one stimulus cycle from 1 unit after a rising edge to 1 unit after the next
    task automatic run_cycle(input logic lk, input logic [31:0] pc, input logic allow,
                             input bpu_pkg::br_result_t br);
        lookup_rec_t rec;
        pre_pc     = pc;
        pc_valid   = lk;
        ds_allowin = allow;
        br_result  = br;
        rec.stamp  = cyc;
        rec.lk     = lk;
        rec.pc     = pc;
        if (lk && wr_pend) begin
            rec.exp.hit    = 1'b0; // port taken by the write
            rec.exp.target = pc + 32'd4;
            rec.exp.count  = 2'b00;
        end else begin
            rec.exp = expect_pred(pc);
        end
        rec_q.push_back(rec);
        @(posedge clk);
        if (wr_pend) begin
            write_model(wr_br); // lands at this edge
        end
        wr_pend = br.is_branch;
        wr_br   = br;
        #1;
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 32'h0, 1'b1, '0);
    endtask

    task automatic lookup_pc(input logic [31:0] pc, input logic allow);
        run_cycle(1'b1, pc, allow, '0);
    endtask

    task automatic send_branch(input logic [31:0] pc, input logic [1:0] old_count,
                               input logic taken, input logic [31:0] target);
        run_cycle(1'b0, 32'h0, 1'b1, make_branch(pc, old_count, taken, target));
    endtask

    task automatic cold_misses();
        for (int i = 0; i < 8; i++) begin
            lookup_pc(random_pc(), 1'b1);
        end
    endtask

    task automatic taken_and_not_taken();
        send_branch(pc_a, bpu_pkg::cnt_w_taken, 1'b1, tgt_a);
        send_branch(pc_b, bpu_pkg::cnt_w_taken, 1'b0, random_pc());
        idle_cycle();
        lookup_pc(pc_a, 1'b1);
        lookup_pc(pc_b, 1'b1); // weak not-taken so it falls through
    endtask

    task automatic counter_walk();
        logic taken;
        for (int i = 0; i < 12; i++) begin
            taken = (i == 0) || (i >= 6); // saturate taken then walk down and back up
            send_branch(pc_a, model_count(pc_a), taken, tgt_a);
            idle_cycle();
            lookup_pc(pc_a, 1'b1);
        end
    endtask

    task automatic index_alias();
        lookup_pc(pc_c, 1'b1);
        send_branch(pc_c, bpu_pkg::cnt_w_taken, 1'b1, tgt_c);
        idle_cycle();
        lookup_pc(pc_c, 1'b1);
        lookup_pc(pc_a, 1'b1); // evicted by pc_c
    endtask

    task automatic write_conflict();
        send_branch(pc_d, bpu_pkg::cnt_wn_taken, 1'b1, tgt_d);
        lookup_pc(pc_b, 1'b1); // same cycle as the write
        lookup_pc(pc_b, 1'b1);
        lookup_pc(pc_d, 1'b1);
    endtask

    task automatic decode_stall();
        lookup_pc(pc_b, 1'b1);
        lookup_pc(pc_c, 1'b1);
        lookup_pc(pc_d, 1'b0);
        lookup_pc(random_pc(), 1'b0);
        lookup_pc(pc_c, 1'b0);
        lookup_pc(pc_d, 1'b1); // loads the pc_c prediction
        idle_cycle();
    endtask

    task automatic random_traffic();
        logic [31:0] pool [4];
        logic [31:0] r;
        bpu_pkg::br_result_t br;
        pool = '{pc_a, pc_b, pc_c, pc_d};
        for (int i = 0; i < 48; i++) begin
            r  = $random(seed);
            br = r[2] ? make_branch(pool[r[1:0]], r[4:3], r[5], random_pc()) : '0;
            run_cycle(r[6], pool[r[9:8]], r[7] | r[10], br);
        end
    endtask

    // compares lookup outputs and ds_bus against the recorded expectations
    initial begin : compare
        lookup_rec_t      rec;
        bpu_pkg::bpu_ds_t next_ds;
        exp_ds = '0;
        forever begin
            @(negedge clk);
            if (reset) begin
                exp_ds = '0;
            end else begin
                assert (ds_bus == exp_ds) else begin
                    ds_errors++;
                    $display("MISMATCH at %0t: ds_bus %h, expected %h", $time, ds_bus, exp_ds);
                end
                next_ds = '0;
                if (rec_q.size() > 0 && rec_q[0].stamp == cyc - 1) begin
                    rec = rec_q.pop_front();
                    if (rec.lk) begin
                        assert (lookup_hit == rec.exp.hit &&
                                lookup_target == rec.exp.target) else begin
                            lookup_errors++;
                            $display("MISMATCH at %0t: pc %h hit %b target %h, expected %b %h",
                                     $time, rec.pc, lookup_hit, lookup_target,
                                     rec.exp.hit, rec.exp.target);
                        end
                        if (rec.exp.hit) begin
                            next_ds.taken   = ~rec.exp.count[1];
                            next_ds.count   = rec.exp.count;
                            next_ds.valid   = 1'b1;
                            next_ds.next_pc = rec.exp.target;
                        end
                    end
                end
                if (ds_allowin) begin
                    exp_ds = next_ds; // loads at the coming edge
                end
            end
        end
    end

    initial begin : stimulus
        int n;
        clk        = 1'b0;
        reset      = 1'b1;
        pre_pc     = '0;
        pc_valid   = 1'b0;
        ds_allowin = 1'b0;
        br_result  = '0;
        seed       = 32'h0f52_996c;
        wr_pend    = 1'b0;
        wr_br      = '0;
        clear_model();
        pc_a  = random_pc();
        pc_b  = pc_a + 32'd4;
        pc_d  = pc_a + 32'd8;
        pc_c  = pc_a + PHT_ENTRIES * 4; // same index but another tag
        tgt_a = random_pc();
        tgt_c = random_pc();
        tgt_d = random_pc();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        for (n = 0; n < 4 * PHT_ENTRIES && !bpu_ready; n++) begin
            idle_cycle();
        end
        if (bpu_ready) begin
            assert (n == PHT_ENTRIES) else begin
                ready_errors++;
                $display("MISMATCH at %0t: bpu_ready after %0d cycles, expected %0d",
                         $time, n, PHT_ENTRIES);
            end
            cold_misses();
            taken_and_not_taken();
            counter_walk();
            index_alias();
            write_conflict();
            decode_stall();
            random_traffic();
        end else begin
            timeout_errors++;
            $display("bpu_ready did not rise within %0d cycles after reset", 4 * PHT_ENTRIES);
        end
        repeat (3) idle_cycle(); // last lookup and its ds_bus load get checked

        $display("errors: lookup %0d, ds_bus %0d, ready %0d, timeout %0d",
                 lookup_errors, ds_errors, ready_errors, timeout_errors);
        if (lookup_errors + ds_errors + ready_errors + timeout_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tb
rtl/bpu_pkg.sv
rtl/pht_if.sv
rtl/pht_ram.sv
rtl/pht_arbiter.sv
rtl/bpu_lookup.sv
rtl/bpu_update.sv
rtl/bpu_top.sv
tb/bpu_tb.sv
